/* flist.f */
+incdir+src
src/issue_pkg.sv
src/fu_pkg.sv
src/fu_fifo.sv
src/fu_fifo_bank.sv
src/issue_router.sv
src/issue_fifo_top.sv
sim/issue_fifo_checker.sv
sim/tb_issue_fifo.sv

/* sim/issue_fifo_checker.sv */
// ===============================================
// Reference queue model of the issue FIFO stage
// Compares accept levels, popped packets and status on each rising edge
// ===============================================
`timescale 1ns/10ps
`include "issue_cfg.svh"

module issue_fifo_checker (
    input  logic                                        clock,
    input  logic                                        reset,
    input  issue_pkg::issue_packet_t [`ISSUE_WIDTH-1:0] issue_slots_i,
    input  logic [`ISSUE_WIDTH-1:0]                     exp_accept_i,
    input  logic [`ISSUE_WIDTH-1:0]                     slot_accepted_i,
    input  logic [`FU_NUM-1:0]                          fu_rd_en_i,
    input  issue_pkg::issue_packet_t [`FU_NUM-1:0]      fu_pkt_i,
    input  fu_pkg::fu_status_t [`FU_NUM-1:0]            fu_status_i,
    output int                                          error_count_o
);

    // One reference queue per FU, head at index 0
    issue_pkg::issue_packet_t model_q [`FU_NUM][$];
    logic [`ISSUE_WIDTH-1:0]  model_acc;
    int                       model_target [`ISSUE_WIDTH];
    issue_pkg::issue_packet_t exp_pkt;
    fu_pkg::fu_status_t       exp_status;
    int                       errors = 0;

    assign error_count_o = errors;

    task automatic flag_mismatch(string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    // Free slots, capped at issue width
    function automatic int model_credit(int f);
        int free_slots;
        free_slots = `FIFO_DEPTH - model_q[f].size();
        return (free_slots > `ISSUE_WIDTH) ? `ISSUE_WIDTH : free_slots;
    endfunction

    // ===============================================
    // Expected steering, slot 0 first
    // ===============================================
    task automatic predict_routing();
        logic [`FU_NUM-1:0] claimed;
        logic               blocked;
        logic               found;
        int                 target;
        claimed   = '0;
        blocked   = 1'b0;
        model_acc = '0;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            found  = 1'b0;
            target = `BRANCH_FU_IDX;
            case (issue_slots_i[s].fu_class)
                issue_pkg::FU_ALU: begin
                    // Lowest ALU FIFO with credit that nobody took yet
                    for (int a = `ALU_FIFO_NUM - 1; a >= 0; a--) begin
                        if (model_credit(a) > 0 && !claimed[a]) begin
                            found  = 1'b1;
                            target = a;
                        end
                    end
                end
                issue_pkg::FU_MUL:  target = `MUL_FU_IDX;
                issue_pkg::FU_LOAD: target = `LOAD_FU_IDX;
                default:            target = `BRANCH_FU_IDX;
            endcase
            if (issue_slots_i[s].fu_class != issue_pkg::FU_ALU) begin
                found = (model_credit(target) > 0) && !claimed[target];
            end
            if (issue_slots_i[s].valid && !blocked && found) begin
                claimed[target] = 1'b1;
                model_acc[s]    = 1'b1;
                model_target[s] = target;
            end else if (issue_slots_i[s].valid) begin
                blocked = 1'b1;
            end
        end
    endtask

    // ===============================================
    // Compare, then advance the model
    // ===============================================
    always @(posedge clock) begin
        if (reset) begin
            for (int f = 0; f < `FU_NUM; f++) begin
                model_q[f].delete();
            end
        end else begin
            predict_routing();
            if (slot_accepted_i !== model_acc || slot_accepted_i !== exp_accept_i) begin
                flag_mismatch($sformatf("slot_accepted %b, model %b, table %b",
                                        slot_accepted_i, model_acc, exp_accept_i));
            end
            for (int f = 0; f < `FU_NUM; f++) begin
                exp_status.empty  = (model_q[f].size() == 0);
                exp_status.full   = (model_q[f].size() == `FIFO_DEPTH);
                exp_status.credit = fu_pkg::fu_credit_t'(model_credit(f));
                if (fu_status_i[f] !== exp_status) begin
                    flag_mismatch($sformatf("FU %0d status %b, expected %b",
                                            f, fu_status_i[f], exp_status));
                end
                // Pop only from a non-empty queue, zero packet otherwise
                exp_pkt = '0;
                if (fu_rd_en_i[f] && model_q[f].size() != 0) begin
                    exp_pkt = model_q[f].pop_front();
                end
                if (fu_pkt_i[f] !== exp_pkt) begin
                    flag_mismatch($sformatf("FU %0d popped tag %0d valid %b, expected tag %0d valid %b",
                                            f, fu_pkt_i[f].rob_tag, fu_pkt_i[f].valid,
                                            exp_pkt.rob_tag, exp_pkt.valid));
                end
            end
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                if (model_acc[s]) begin
                    model_q[model_target[s]].push_back(issue_slots_i[s]);
                end
            end
        end
    end

endmodule

/* sim/tb_issue_fifo.sv */
// ===============================================
// Testbench for the issue FIFO stage, table rows applied on falling edges
// Comparison happens in issue_fifo_checker
// ===============================================
`timescale 1ns/10ps
`include "issue_cfg.svh"

module tb_issue_fifo;

    localparam int RESET_CYCLES = 10;

    // Two slots, FU read mask, expected accept levels
    typedef struct packed {
        issue_pkg::issue_packet_t slot1;
        issue_pkg::issue_packet_t slot0;
        logic [`FU_NUM-1:0]       rd_en;
        logic [`ISSUE_WIDTH-1:0]  exp_accept;
    } stim_row_t;

    localparam issue_pkg::issue_packet_t NONE = '0;
    localparam issue_pkg::fu_class_e ALU = issue_pkg::FU_ALU;
    localparam issue_pkg::fu_class_e MUL = issue_pkg::FU_MUL;
    localparam issue_pkg::fu_class_e LD  = issue_pkg::FU_LOAD;
    localparam issue_pkg::fu_class_e BR  = issue_pkg::FU_BRANCH;

    logic                                        clock;
    logic                                        reset;
    issue_pkg::issue_packet_t [`ISSUE_WIDTH-1:0] issue_slots;
    logic [`ISSUE_WIDTH-1:0]                     slot_accepted;
    logic [`ISSUE_WIDTH-1:0]                     exp_accept;
    logic [`FU_NUM-1:0]                          fu_rd_en;
    issue_pkg::issue_packet_t [`FU_NUM-1:0]      fu_pkt;
    fu_pkg::fu_status_t [`FU_NUM-1:0]            fu_status;
    int                                          error_count;
    int                                          cycle_count;
    int                                          cycle_limit;
    integer                                      seed;
    stim_row_t                                   stim_table [$];

    issue_fifo_top i_issue_fifo_top (
        .clock           (clock),
        .reset           (reset),
        .issue_slots_i   (issue_slots),
        .slot_accepted_o (slot_accepted),
        .fu_rd_en_i      (fu_rd_en),
        .fu_pkt_o        (fu_pkt),
        .fu_status_o     (fu_status)
    );

    issue_fifo_checker u_checker (
        .clock           (clock),
        .reset           (reset),
        .issue_slots_i   (issue_slots),
        .exp_accept_i    (exp_accept),
        .slot_accepted_i (slot_accepted),
        .fu_rd_en_i      (fu_rd_en),
        .fu_pkt_i        (fu_pkt),
        .fu_status_i     (fu_status),
        .error_count_o   (error_count)
    );

    // Valid packet, destination tied to the tag, random operands
    function automatic issue_pkg::issue_packet_t make_packet(issue_pkg::fu_class_e cls, int tag);
        issue_pkg::issue_packet_t p;
        p.valid     = 1'b1;
        p.fu_class  = cls;
        p.rob_tag   = issue_pkg::rob_tag_t'(tag);
        p.dest_preg = {1'b1, p.rob_tag};
        p.src1_val  = {$random(seed), $random(seed)};
        p.src2_val  = {$random(seed), $random(seed)};
        return p;
    endfunction

    task automatic add_row(issue_pkg::issue_packet_t s0, issue_pkg::issue_packet_t s1,
                           logic [`FU_NUM-1:0] rd, logic [`ISSUE_WIDTH-1:0] acc);
        stim_table.push_back('{s1, s0, rd, acc});
    endtask

    task automatic apply_row(stim_row_t row);
        issue_slots[0] = row.slot0;
        issue_slots[1] = row.slot1;
        fu_rd_en       = row.rd_en;
        exp_accept     = row.exp_accept;
    endtask

    // ===============================================
    // Stimulus table, read mask is {BR, LD, MUL, ALU2, ALU1, ALU0}
    // ===============================================
    task automatic load_table();
        // Reset state, pop every empty FIFO
        add_row(NONE, NONE, 6'h3F, 2'b00);
        // Class routing and in-order pops
        add_row(make_packet(ALU, 1), make_packet(ALU, 2), 6'h00, 2'b11);
        add_row(make_packet(MUL, 3), make_packet(LD, 4), 6'h00, 2'b11);
        add_row(NONE, make_packet(BR, 5), 6'h03, 2'b10);
        add_row(NONE, NONE, 6'h38, 2'b00);
        // Both slots want MUL
        add_row(make_packet(MUL, 6), make_packet(MUL, 7), 6'h00, 2'b01);
        add_row(make_packet(MUL, 7), make_packet(LD, 8), 6'h00, 2'b11);
        add_row(make_packet(MUL, 9), NONE, 6'h00, 2'b01);
        add_row(make_packet(MUL, 10), make_packet(ALU, 11), 6'h00, 2'b11);
        // MUL full, rejected slot 0 blocks slot 1
        add_row(make_packet(MUL, 12), make_packet(ALU, 13), 6'h00, 2'b00);
        add_row(make_packet(MUL, 12), NONE, 6'h08, 2'b00);
        // Push and pop on MUL, tail wraps
        add_row(make_packet(MUL, 12), NONE, 6'h08, 2'b01);
        add_row(NONE, NONE, 6'h19, 2'b00);
        // Fill ALU0, credit 2 2 2 1 0
        add_row(make_packet(ALU, 14), NONE, 6'h08, 2'b01);
        add_row(make_packet(ALU, 15), NONE, 6'h08, 2'b01);
        add_row(make_packet(ALU, 16), NONE, 6'h00, 2'b01);
        add_row(make_packet(ALU, 17), NONE, 6'h00, 2'b01);
        // Spill into ALU1 and ALU2
        add_row(make_packet(ALU, 18), make_packet(ALU, 19), 6'h00, 2'b11);
        add_row(make_packet(ALU, 20), make_packet(ALU, 21), 6'h00, 2'b11);
        // Pop with push on ALU0 across the wrap
        add_row(NONE, NONE, 6'h01, 2'b00);
        add_row(make_packet(ALU, 22), NONE, 6'h01, 2'b01);
        add_row(make_packet(ALU, 23), make_packet(ALU, 24), 6'h01, 2'b11);
        // Drain
        add_row(NONE, NONE, 6'h07, 2'b00);
        add_row(NONE, NONE, 6'h07, 2'b00);
        add_row(NONE, NONE, 6'h3F, 2'b00);
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        reset       = 1'b1;
        issue_slots = '0;
        fu_rd_en    = '0;
        exp_accept  = '0;
        seed        = 46;
        load_table();
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        foreach (stim_table[r]) begin
            apply_row(stim_table[r]);
            @(negedge clock);
        end
        apply_row('0);
        @(negedge clock);
        $display("Done: %0d rows applied, %0d errors", stim_table.size(), error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Run limit from table length, reset and some slack
    initial begin
        cycle_count = 0;
        #1;
        cycle_limit = stim_table.size() + RESET_CYCLES + 20;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: stimulus did not finish within %0d clock cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* src/fu_fifo.sv */
// ===============================================
// Circular FIFO of issue packets for one functional unit
// Head is readable combinationally, pop and push may overlap
// ===============================================
`timescale 1ns/10ps
`include "issue_cfg.svh"

module fu_fifo #(
    parameter int unsigned FIFO_DEPTH  = `FIFO_DEPTH,
    parameter int unsigned ISSUE_WIDTH = `ISSUE_WIDTH
) (
    input  logic                    clock,
    input  logic                    reset,

    // Router side
    input  logic                    wr_en_i,
    input  issue_pkg::issue_packet_t wr_pkt_i,

    // FU side
    input  logic                    rd_en_i,
    output issue_pkg::issue_packet_t rd_pkt_o,
    output fu_pkg::fu_status_t      status_o
);

    localparam int unsigned CNT_BITS = $clog2(FIFO_DEPTH + 1);
    localparam int unsigned PTR_BITS = $clog2(FIFO_DEPTH);
    localparam logic [PTR_BITS-1:0] PTR_MAX = PTR_BITS'(FIFO_DEPTH - 1);

    // Storage
    issue_pkg::issue_packet_t mem [FIFO_DEPTH];

    // Head is next read slot, tail is next write slot
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [CNT_BITS-1:0] count;
    logic [CNT_BITS-1:0] count_next;
    logic [CNT_BITS-1:0] free_slots;

    logic empty;
    logic rd_valid;

    // ===============================================
    // Status
    // ===============================================
    assign empty      = (count == '0);
    assign free_slots = CNT_BITS'(FIFO_DEPTH) - count;

    assign status_o.empty  = empty;
    assign status_o.full   = (count == CNT_BITS'(FIFO_DEPTH));
    // Router never needs more than one slot per issue lane
    assign status_o.credit = (int'(free_slots) >= ISSUE_WIDTH) ?
                             fu_pkg::fu_credit_t'(ISSUE_WIDTH) :
                             fu_pkg::fu_credit_t'(free_slots);

    // Pop only when something is there
    assign rd_valid = rd_en_i && !empty;

    // ===============================================
    // Pointers and count
    // ===============================================
    always_comb begin
        count_next = count;
        case ({wr_en_i, rd_valid})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            // Push with pop keeps the count
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wr_en_i) begin
                tail <= (tail == PTR_MAX) ? '0 : tail + 1'b1;
            end
            if (rd_valid) begin
                head <= (head == PTR_MAX) ? '0 : head + 1'b1;
            end
            count <= count_next;
        end
    end

    // ===============================================
    // Data path
    // ===============================================
    // Write trusts the router credit check
    always_ff @(posedge clock) begin
        if (wr_en_i) begin
            mem[tail] <= wr_pkt_i;
        end
    end

    // Zero-latency read, zero when nothing pops
    assign rd_pkt_o = rd_valid ? mem[head] : '0;

endmodule

/* src/fu_fifo_bank.sv */
// ===============================================
// One fu_fifo per functional unit, status gathered per FU
// ===============================================
`timescale 1ns/10ps
`include "issue_cfg.svh"

module fu_fifo_bank (
    input  logic                                   clock,
    input  logic                                   reset,

    // Router side
    input  logic [`FU_NUM-1:0]                     wr_en_i,
    input  issue_pkg::issue_packet_t [`FU_NUM-1:0] wr_pkt_i,

    // FU side
    input  logic [`FU_NUM-1:0]                     rd_en_i,
    output issue_pkg::issue_packet_t [`FU_NUM-1:0] rd_pkt_o,
    output fu_pkg::fu_status_t [`FU_NUM-1:0]       status_o
);

    // Dedicated units, one FIFO each
    localparam int unsigned UNIT_IDX [3] = '{`MUL_FU_IDX, `LOAD_FU_IDX, `BRANCH_FU_IDX};

    // ALU FIFOs, indices 0 up to ALU_FIFO_NUM-1
    for (genvar i = 0; i < `ALU_FIFO_NUM; i++) begin : g_alu_fifo
        fu_fifo u_fifo (
            .clock    (clock),
            .reset    (reset),
            .wr_en_i  (wr_en_i[i]),
            .wr_pkt_i (wr_pkt_i[i]),
            .rd_en_i  (rd_en_i[i]),
            .rd_pkt_o (rd_pkt_o[i]),
            .status_o (status_o[i])
        );
    end

    // MUL, LOAD and BRANCH FIFOs
    for (genvar j = 0; j < 3; j++) begin : g_unit_fifo
        fu_fifo u_fifo (
            .clock    (clock),
            .reset    (reset),
            .wr_en_i  (wr_en_i[UNIT_IDX[j]]),
            .wr_pkt_i (wr_pkt_i[UNIT_IDX[j]]),
            .rd_en_i  (rd_en_i[UNIT_IDX[j]]),
            .rd_pkt_o (rd_pkt_o[UNIT_IDX[j]]),
            .status_o (status_o[UNIT_IDX[j]])
        );
    end

endmodule

/* src/fu_pkg.sv */
// ===============================================
// FU-side types: FU index, credit and FIFO status
// ===============================================
`include "issue_cfg.svh"

package fu_pkg;

    // Index into the FIFO bank
    typedef logic [2:0] fu_id_t;

    // Free slots, saturated at issue width
    typedef logic [`FIFO_CNT_BITS-1:0] fu_credit_t;

    // Per-FIFO status seen by router and FU
    typedef struct packed {
        logic       empty;
        logic       full;
        fu_credit_t credit;
    } fu_status_t;

endpackage

/* src/issue_cfg.svh */
// ===============================================
// Sizing constants for the issue-to-execute FIFO stage
// Include wherever widths or FU indices are needed
// ===============================================
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// Issue side
`define ISSUE_WIDTH    2
`define XLEN           64

// FIFO bank geometry
`define FU_NUM         6
`define FIFO_DEPTH     4
// Count spans 0..DEPTH, pointer spans 0..DEPTH-1
`define FIFO_CNT_BITS  3
`define FIFO_PTR_BITS  2

// FU index map, ALUs first
`define ALU_FIFO_NUM   3
`define MUL_FU_IDX     3
`define LOAD_FU_IDX    4
`define BRANCH_FU_IDX  5

`endif

/* src/issue_fifo_top.sv */
// ===============================================
// Issue-to-execute buffer stage, router in front of the FIFO bank
// ===============================================
`timescale 1ns/10ps
`include "issue_cfg.svh"

module issue_fifo_top (
    input  logic                                        clock,
    input  logic                                        reset,

    // Issue side
    input  issue_pkg::issue_packet_t [`ISSUE_WIDTH-1:0] issue_slots_i,
    output logic [`ISSUE_WIDTH-1:0]                     slot_accepted_o,

    // FU side
    input  logic [`FU_NUM-1:0]                          fu_rd_en_i,
    output issue_pkg::issue_packet_t [`FU_NUM-1:0]      fu_pkt_o,
    output fu_pkg::fu_status_t [`FU_NUM-1:0]            fu_status_o
);

    // Router to bank
    logic [`FU_NUM-1:0]                     fifo_wr_en;
    issue_pkg::issue_packet_t [`FU_NUM-1:0] fifo_wr_pkt;
    // Bank status, shared by router and FUs
    fu_pkg::fu_status_t [`FU_NUM-1:0]       fu_status;

    issue_router u_router (
        .issue_slots_i   (issue_slots_i),
        .fu_status_i     (fu_status),
        .slot_accepted_o (slot_accepted_o),
        .fifo_wr_en_o    (fifo_wr_en),
        .fifo_wr_pkt_o   (fifo_wr_pkt)
    );

    fu_fifo_bank u_bank (
        .clock    (clock),
        .reset    (reset),
        .wr_en_i  (fifo_wr_en),
        .wr_pkt_i (fifo_wr_pkt),
        .rd_en_i  (fu_rd_en_i),
        .rd_pkt_o (fu_pkt_o),
        .status_o (fu_status)
    );

    assign fu_status_o = fu_status;

endmodule

/* src/issue_pkg.sv */
// ===============================================
// Instruction-side types carried from issue to the FUs
// ===============================================
`include "issue_cfg.svh"

package issue_pkg;

    // Functional unit class tag
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MUL    = 2'd1,
        FU_LOAD   = 2'd2,
        FU_BRANCH = 2'd3
    } fu_class_e;

    // Reorder buffer tag
    typedef logic [4:0] rob_tag_t;
    // Physical register number
    typedef logic [5:0] preg_t;
    // Operand word
    typedef logic [`XLEN-1:0] xlen_t;

    // Issue packet, 142 bits at XLEN 64
    typedef struct packed {
        logic      valid;
        fu_class_e fu_class;
        rob_tag_t  rob_tag;
        preg_t     dest_preg;
        xlen_t     src1_val;
        xlen_t     src2_val;
    } issue_packet_t;

endpackage

/* src/issue_router.sv */
// ===============================================
// Steers issue slots into FU FIFOs by class and credit
// Slots are taken in order, a rejected slot blocks the rest
// ===============================================
`timescale 1ns/10ps
`include "issue_cfg.svh"

module issue_router (
    // Issue slots in
    input  issue_pkg::issue_packet_t [`ISSUE_WIDTH-1:0] issue_slots_i,
    // Status from the bank
    input  fu_pkg::fu_status_t [`FU_NUM-1:0]            fu_status_i,

    output logic [`ISSUE_WIDTH-1:0]                     slot_accepted_o,
    output logic [`FU_NUM-1:0]                          fifo_wr_en_o,
    output issue_pkg::issue_packet_t [`FU_NUM-1:0]      fifo_wr_pkt_o
);

    // FIFO has room this cycle
    logic [`FU_NUM-1:0] writable;
    // FIFOs already taken by an earlier slot
    logic [`FU_NUM-1:0] claimed;
    // Writable and still free for this slot
    logic [`FU_NUM-1:0] avail;

    issue_pkg::issue_packet_t pkt;
    fu_pkg::fu_id_t           target;
    logic                     found;
    // Low once a valid slot has been turned away
    logic                     in_order;

    // ===============================================
    // Credit check
    // ===============================================
    always_comb begin
        for (int f = 0; f < `FU_NUM; f++) begin
            writable[f] = (fu_status_i[f].credit != '0);
        end
    end

    // ===============================================
    // Slot steering, slot 0 first
    // ===============================================
    always_comb begin
        claimed         = '0;
        avail           = '0;
        pkt             = '0;
        target          = '0;
        found           = 1'b0;
        in_order        = 1'b1;
        slot_accepted_o = '0;
        fifo_wr_en_o    = '0;
        fifo_wr_pkt_o   = '0;

        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            pkt    = issue_slots_i[s];
            avail  = writable & ~claimed;
            found  = 1'b0;
            target = '0;

            case (pkt.fu_class)
                issue_pkg::FU_ALU: begin
                    // Walk down so the lowest free ALU wins
                    for (int a = `ALU_FIFO_NUM - 1; a >= 0; a--) begin
                        if (avail[a]) begin
                            found  = 1'b1;
                            target = fu_pkg::fu_id_t'(a);
                        end
                    end
                end
                issue_pkg::FU_MUL:  target = fu_pkg::fu_id_t'(`MUL_FU_IDX);
                issue_pkg::FU_LOAD: target = fu_pkg::fu_id_t'(`LOAD_FU_IDX);
                default:            target = fu_pkg::fu_id_t'(`BRANCH_FU_IDX);
            endcase

            // Fixed-unit classes only have their own FIFO
            if (pkt.fu_class != issue_pkg::FU_ALU) begin
                found = avail[target];
            end

            if (in_order && pkt.valid && found) begin
                claimed[target]       = 1'b1;
                fifo_wr_en_o[target]  = 1'b1;
                fifo_wr_pkt_o[target] = pkt;
                slot_accepted_o[s]    = 1'b1;
            end else if (pkt.valid) begin
                // Later slots must wait behind this one
                in_order = 1'b0;
            end
        end
    end

endmodule
